// File: id_pkg.sv
package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // RV32I major opcodes
    localparam logic [6:0] OPC_I_ALU  = 7'b0010011;
    localparam logic [6:0] OPC_R      = 7'b0110011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000; // ADD, SRL
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA

    typedef enum logic [7:0] {
        ALU_NOP,
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_OR, ALU_AND, ALU_SRL, ALU_SRA,
        ALU_ADDI, ALU_SLTI, ALU_SLTIU, ALU_XORI, ALU_ORI,
        ALU_ANDI, ALU_SLLI, ALU_SRLI, ALU_SRAI,
        ALU_LUI, ALU_AUIPC, ALU_JAL, ALU_JALR,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_ALU,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_UPPER
    } inst_class_e;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

    typedef struct packed {
        alu_op_e     alu_op;
        inst_class_e cls;
        logic        rs1_read;
        logic        rs2_read;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        logic        we;
        logic        auipc;
    } dec_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        reg_addr_t rd;
        logic      we;
        word_t     op1;
        word_t     op2;
        word_t     imm;
        word_t     link;
    } id_ex_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

// File: id_imm_gen.sv
`timescale 1ns/1ps

module id_imm_gen import id_pkg::*; (
    input  word_t inst_i,
    output word_t imm_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];

    always_comb
    begin
        case (opcode)
            OPC_I_ALU:
            begin
                if (funct3 == F3_SLL || funct3 == F3_SR)
                    imm_o = {{(XLEN-5){1'b0}}, inst_i[24:20]}; // Shift amount only
                else
                    imm_o = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
            end
            OPC_JALR:
                imm_o = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
            OPC_BRANCH:
                imm_o = {{(XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                         inst_i[30:25], inst_i[11:8], 1'b0};
            OPC_JAL:
                imm_o = {{(XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                         inst_i[20], inst_i[30:21], 1'b0};
            OPC_LUI, OPC_AUIPC:
                imm_o = {inst_i[31:12], 12'b0};
            default:
                imm_o = '0;
        endcase
    end

endmodule

// File: id_decoder.sv
`timescale 1ns/1ps

module id_decoder import id_pkg::*; (
    input  word_t inst_i,
    output dec_t  dec_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       funct_ok;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    always_comb
    begin
        dec_o          = '0;
        dec_o.alu_op   = ALU_NOP;
        dec_o.cls      = CLS_NONE;
        dec_o.rs1      = inst_i[19:15];
        dec_o.rs2      = inst_i[24:20];
        dec_o.rd       = inst_i[11:7];
        funct_ok       = 1'b1;

        case (opcode)
            OPC_I_ALU:
            begin
                dec_o.cls      = CLS_ALU;
                dec_o.rs1_read = 1'b1;
                dec_o.we       = 1'b1;
                case (funct3)
                    F3_ADD:
                        dec_o.alu_op = ALU_ADDI;
                    F3_SLT:
                        dec_o.alu_op = ALU_SLTI;
                    F3_SLTU:
                        dec_o.alu_op = ALU_SLTIU;
                    F3_XOR:
                        dec_o.alu_op = ALU_XORI;
                    F3_OR:
                        dec_o.alu_op = ALU_ORI;
                    F3_AND:
                        dec_o.alu_op = ALU_ANDI;
                    F3_SLL:
                        dec_o.alu_op = ALU_SLLI;
                    default:
                    begin
                        if (funct7 == F7_BASE)
                            dec_o.alu_op = ALU_SRLI;
                        else if (funct7 == F7_ALT)
                            dec_o.alu_op = ALU_SRAI;
                        else
                            funct_ok = 1'b0;
                    end
                endcase
            end
            OPC_R:
            begin
                dec_o.cls      = CLS_ALU;
                dec_o.rs1_read = 1'b1;
                dec_o.rs2_read = 1'b1;
                dec_o.we       = 1'b1;
                case (funct3)
                    F3_ADD:
                    begin
                        if (funct7 == F7_BASE)
                            dec_o.alu_op = ALU_ADD;
                        else if (funct7 == F7_ALT)
                            dec_o.alu_op = ALU_SUB;
                        else
                            funct_ok = 1'b0;
                    end
                    F3_SR:
                    begin
                        if (funct7 == F7_BASE)
                            dec_o.alu_op = ALU_SRL;
                        else if (funct7 == F7_ALT)
                            dec_o.alu_op = ALU_SRA;
                        else
                            funct_ok = 1'b0;
                    end
                    F3_SLL:
                        dec_o.alu_op = ALU_SLL;
                    F3_SLT:
                        dec_o.alu_op = ALU_SLT;
                    F3_SLTU:
                        dec_o.alu_op = ALU_SLTU;
                    F3_XOR:
                        dec_o.alu_op = ALU_XOR;
                    F3_OR:
                        dec_o.alu_op = ALU_OR;
                    default:
                        dec_o.alu_op = ALU_AND;
                endcase
            end
            OPC_BRANCH:
            begin
                dec_o.cls      = CLS_BRANCH;
                dec_o.rs1_read = 1'b1;
                dec_o.rs2_read = 1'b1;
                case (funct3)
                    F3_BEQ:
                        dec_o.alu_op = ALU_BEQ;
                    F3_BNE:
                        dec_o.alu_op = ALU_BNE;
                    F3_BLT:
                        dec_o.alu_op = ALU_BLT;
                    F3_BGE:
                        dec_o.alu_op = ALU_BGE;
                    F3_BLTU:
                        dec_o.alu_op = ALU_BLTU;
                    F3_BGEU:
                        dec_o.alu_op = ALU_BGEU;
                    default:
                        funct_ok = 1'b0; // 010 and 011 are reserved
                endcase
            end
            OPC_JAL:
            begin
                dec_o.cls    = CLS_JAL;
                dec_o.alu_op = ALU_JAL;
                dec_o.we     = 1'b1;
            end
            OPC_JALR:
            begin
                dec_o.cls      = CLS_JALR;
                dec_o.alu_op   = ALU_JALR;
                dec_o.rs1_read = 1'b1;
                dec_o.we       = 1'b1;
            end
            OPC_LUI:
            begin
                dec_o.cls    = CLS_UPPER;
                dec_o.alu_op = ALU_LUI;
                dec_o.we     = 1'b1;
            end
            OPC_AUIPC:
            begin
                dec_o.cls    = CLS_UPPER;
                dec_o.alu_op = ALU_AUIPC;
                dec_o.we     = 1'b1;
                dec_o.auipc  = 1'b1; // Operand 1 takes the pc
            end
            default:
            begin
            end
        endcase

        if (!funct_ok)
        begin
            dec_o.alu_op   = ALU_NOP;
            dec_o.cls      = CLS_NONE;
            dec_o.rs1_read = 1'b0;
            dec_o.rs2_read = 1'b0;
            dec_o.we       = 1'b0;
        end
    end

endmodule

// File: id_regfile.sv
`timescale 1ns/1ps

module id_regfile import id_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  wb_t       wb_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_i.we && wb_i.addr != '0)
        begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // Same-cycle read sees the old value
    assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// File: id_operand_mux.sv
`timescale 1ns/1ps

module id_operand_mux import id_pkg::*; (
    input  logic      read_i,
    input  reg_addr_t addr_i,
    input  word_t     rf_data_i,
    input  word_t     alt_i,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      mem_fwd_i,
    output word_t     op_o
);

    logic ex_hit;
    logic mem_hit;

    // x0 never matches a forward
    assign ex_hit  = ex_fwd_i.we && ex_fwd_i.rd == addr_i && addr_i != '0;
    assign mem_hit = mem_fwd_i.we && mem_fwd_i.rd == addr_i && addr_i != '0;

    always_comb
    begin
        if (!read_i)
            op_o = alt_i; // Immediate or pc
        else if (ex_hit)
            op_o = ex_fwd_i.data; // Execute beats memory
        else if (mem_hit)
            op_o = mem_fwd_i.data;
        else
            op_o = rf_data_i;
    end

endmodule

// File: id_branch_unit.sv
`timescale 1ns/1ps

module id_branch_unit import id_pkg::*; (
    input  dec_t      dec_i,
    input  word_t     pc_i,
    input  word_t     op1_i,
    input  word_t     op2_i,
    input  word_t     imm_i,
    output redirect_t redirect_o,
    output word_t     link_o
);

    logic  eq;
    logic  lt_s;
    logic  lt_u;
    logic  cond;
    word_t pc_target;
    word_t jalr_sum;

    assign eq   = op1_i == op2_i;
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    assign pc_target = pc_i + imm_i;
    assign jalr_sum  = op1_i + imm_i;
    assign link_o    = pc_i + 32'd4;

    always_comb
    begin
        case (dec_i.alu_op)
            ALU_BEQ:
                cond = eq;
            ALU_BNE:
                cond = !eq;
            ALU_BLT:
                cond = lt_s;
            ALU_BGE:
                cond = !lt_s;
            ALU_BLTU:
                cond = lt_u;
            ALU_BGEU:
                cond = !lt_u;
            default:
                cond = 1'b0;
        endcase
    end

    always_comb
    begin
        redirect_o.taken  = 1'b0;
        redirect_o.target = pc_target;
        case (dec_i.cls)
            CLS_BRANCH:
                redirect_o.taken = cond;
            CLS_JAL:
                redirect_o.taken = 1'b1;
            CLS_JALR:
            begin
                redirect_o.taken  = 1'b1;
                redirect_o.target = {jalr_sum[XLEN-1:1], 1'b0}; // Bit 0 cleared
            end
            default:
            begin
            end
        endcase
    end

endmodule

// File: id_stage.sv
`timescale 1ns/1ps

module id_stage import id_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      rdy_i,
    input  logic      ignore_i,
    input  word_t     pc_i,
    input  word_t     inst_i,
    input  wb_t       wb_i,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      mem_fwd_i,
    output id_ex_t    id_ex_o,
    output redirect_t redirect_o,
    output logic      next_ignore_o
);

    word_t     imm;
    dec_t      dec;
    word_t     rf_data1;
    word_t     rf_data2;
    word_t     op1_alt;
    word_t     op1;
    word_t     op2;
    word_t     link;
    redirect_t redirect_d;
    id_ex_t    id_ex_d;

    id_imm_gen u_imm_gen (
        .inst_i (inst_i),
        .imm_o  (imm)
    );

    id_decoder u_decoder (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    id_regfile #(
        .NUM_REGS (NUM_REGS)
    ) u_regfile (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_i     (wb_i),
        .rs1_i    (dec.rs1),
        .rs2_i    (dec.rs2),
        .rdata1_o (rf_data1),
        .rdata2_o (rf_data2)
    );

    assign op1_alt = dec.auipc ? pc_i : imm;

    id_operand_mux u_op1_mux (
        .read_i    (dec.rs1_read),
        .addr_i    (dec.rs1),
        .rf_data_i (rf_data1),
        .alt_i     (op1_alt),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .op_o      (op1)
    );

    id_operand_mux u_op2_mux (
        .read_i    (dec.rs2_read),
        .addr_i    (dec.rs2),
        .rf_data_i (rf_data2),
        .alt_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .op_o      (op2)
    );

    id_branch_unit u_branch (
        .dec_i      (dec),
        .pc_i       (pc_i),
        .op1_i      (op1),
        .op2_i      (op2),
        .imm_i      (imm),
        .redirect_o (redirect_d),
        .link_o     (link)
    );

    always_comb
    begin
        id_ex_d.valid  = 1'b1;
        id_ex_d.alu_op = dec.alu_op;
        id_ex_d.rd     = dec.rd;
        id_ex_d.we     = dec.we;
        id_ex_d.op1    = op1;
        id_ex_d.op2    = op2;
        id_ex_d.imm    = imm;
        id_ex_d.link   = link;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            id_ex_o    <= '0;
            redirect_o <= '0;
        end
        else if (rdy_i) // Hold while not ready
        begin
            if (ignore_i)
            begin
                id_ex_o    <= '0; // Bubble
                redirect_o <= '0;
            end
            else
            begin
                id_ex_o    <= id_ex_d;
                redirect_o <= redirect_d;
            end
        end
    end

    // Squash the instruction fetched behind a taken jump
    assign next_ignore_o = redirect_o.taken;

endmodule

// File: id_stage_assert.sv
`timescale 1ns/1ps

module id_stage_assert import id_pkg::*; (
    input logic      clk_i,
    input logic      rst_n_i,
    input logic      rdy_i,
    input logic      ignore_i,
    input redirect_t redirect_d_i,
    input id_ex_t    id_ex_i,
    input redirect_t redirect_i,
    input logic      next_ignore_i
);

    // Taken flag loaded at a ready edge, cleared by a bubble
    ignore_follows_taken: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rdy_i |=> next_ignore_i == ($past(redirect_d_i.taken) && !$past(ignore_i)))
        else $error("next_ignore_o differs from the registered taken flag");

    // Outputs frozen across an edge where rdy_i was low
    hold_when_not_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !rdy_i |=> $stable(id_ex_i) && $stable(redirect_i) && $stable(next_ignore_i))
        else $error("outputs changed while rdy_i was low");

    target_aligned: assert property (@(posedge clk_i) redirect_i.taken |-> !redirect_i.target[0])
        else $error("taken redirect has bit 0 of its target set");

endmodule

bind id_stage id_stage_assert u_id_stage_assert (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .rdy_i         (rdy_i),
    .ignore_i      (ignore_i),
    .redirect_d_i  (redirect_d),
    .id_ex_i       (id_ex_o),
    .redirect_i    (redirect_o),
    .next_ignore_i (next_ignore_o)
);

// File: tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
    import id_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int N_RAND       = 60;
    localparam int N_JUMP       = 8;
    localparam int N_UPPER      = 8;
    localparam int N_LEVEL      = 30;
    localparam int TOTAL_CYCLES = 45 + N_RAND + 24 + 2 * N_JUMP + 2 * N_UPPER + 4 * N_LEVEL;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      rdy;
    logic      ignore;
    word_t     pc;
    word_t     inst;
    wb_t       wb;
    fwd_t      ex_fwd;
    fwd_t      mem_fwd;
    id_ex_t    id_ex;
    redirect_t redirect;
    logic      next_ignore;

    word_t     lfsr = 32'h5185;
    word_t     model_regs [32] = '{default: '0};
    id_ex_t    last_ex = '0;
    redirect_t last_rd = '0;
    id_ex_t    exp_ex_q [$];
    redirect_t exp_rd_q [$];
    id_ex_t    cmp_ex;
    redirect_t cmp_rd;
    fwd_t      no_fwd = '0;
    wb_t       no_wb = '0;

    alu_op_e    r_ops [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    alu_op_e    i_ops [8] = '{ALU_ADDI, ALU_SLLI, ALU_SLTI, ALU_SLTIU, ALU_XORI, ALU_SRLI, ALU_ORI,
                              ALU_ANDI};
    alu_op_e    b_ops [8] = '{ALU_BEQ, ALU_BNE, ALU_NOP, ALU_NOP, ALU_BLT, ALU_BGE, ALU_BLTU,
                              ALU_BGEU};
    logic [2:0] br_f3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    word_t      pair_a [4] = '{32'd5, 32'hFFFF_FFFF, 32'd1, 32'h8000_0000}; // Signed edges
    word_t      pair_b [4] = '{32'd5, 32'd1, 32'hFFFF_FFFF, 32'h7FFF_FFFF};

    id_stage #(
        .NUM_REGS (32)
    ) DUT (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .rdy_i         (rdy),
        .ignore_i      (ignore),
        .pc_i          (pc),
        .inst_i        (inst),
        .wb_i          (wb),
        .ex_fwd_i      (ex_fwd),
        .mem_fwd_i     (mem_fwd),
        .id_ex_o       (id_ex),
        .redirect_o    (redirect),
        .next_ignore_o (next_ignore)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r    = {r[XLEN-2:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1; // Galois step
        end
        return r;
    endfunction

    function automatic logic [37:0] rand_write();
        return {1'(rand_bits(1)), 5'(rand_bits(5)), rand_bits(32)};
    endfunction

    function automatic word_t rand_pc();
        return {30'(rand_bits(30)), 2'b00};
    endfunction

    function automatic word_t rand_alu_inst();
        logic [11:0] hi;
        logic [2:0]  f3;
        logic        is_r;
        logic        alt;
        hi   = 12'(rand_bits(12));
        f3   = 3'(rand_bits(3));
        is_r = 1'(rand_bits(1));
        alt  = 1'(rand_bits(1)) && (f3 == F3_SR || (is_r && f3 == F3_ADD));
        if (is_r || f3 == F3_SLL || f3 == F3_SR)
            hi[11:5] = alt ? F7_ALT : F7_BASE; // Only legal funct7 values
        return {hi, 5'(rand_bits(5)), f3, 5'(rand_bits(5)), is_r ? OPC_R : OPC_I_ALU};
    endfunction

    function automatic word_t mixed_inst();
        if (1'(rand_bits(1)))
            return {25'(rand_bits(25)), OPC_JAL};
        return rand_alu_inst();
    endfunction

    function automatic word_t pick_operand(input logic use_reg, input reg_addr_t a,
                                           input word_t alt, input fwd_t ex, input fwd_t mem);
        if (!use_reg)
            return alt;
        if (a == '0)
            return '0;
        if (ex.we && ex.rd == a)
            return ex.data;
        if (mem.we && mem.rd == a)
            return mem.data;
        return model_regs[a];
    endfunction

    function automatic void compute_expected(input word_t inst_v, input word_t pc_v,
                                             input fwd_t ex, input fwd_t mem, input logic rdy_v,
                                             input logic ign_v, output id_ex_t e,
                                             output redirect_t r);
        logic [2:0] f3;
        logic       alt;
        logic       use1;
        logic       use2;
        alu_op_e    op;
        word_t      imm;
        word_t      a;
        word_t      b;
        f3   = inst_v[14:12];
        alt  = inst_v[31:25] == F7_ALT;
        use1 = 1'b0;
        use2 = 1'b0;
        op   = ALU_NOP;
        imm  = '0;
        e    = '0;
        case (inst_v[6:0])
            OPC_R:
            begin
                use1 = 1'b1;
                use2 = 1'b1;
                e.we = 1'b1;
                op   = r_ops[f3];
                if (alt)
                    op = (f3 == F3_ADD) ? ALU_SUB : ALU_SRA;
            end
            OPC_I_ALU:
            begin
                use1 = 1'b1;
                e.we = 1'b1;
                op   = i_ops[f3];
                imm  = {{20{inst_v[31]}}, inst_v[31:20]};
                if (f3 == F3_SLL || f3 == F3_SR)
                    imm = {27'b0, inst_v[24:20]};
                if (f3 == F3_SR && alt)
                    op = ALU_SRAI;
            end
            OPC_BRANCH:
            begin
                use1 = 1'b1;
                use2 = 1'b1;
                op   = b_ops[f3];
                imm  = {{20{inst_v[31]}}, inst_v[7], inst_v[30:25], inst_v[11:8], 1'b0};
            end
            OPC_JAL:
            begin
                e.we = 1'b1;
                op   = ALU_JAL;
                imm  = {{12{inst_v[31]}}, inst_v[19:12], inst_v[20], inst_v[30:21], 1'b0};
            end
            OPC_JALR:
            begin
                use1 = 1'b1;
                e.we = 1'b1;
                op   = ALU_JALR;
                imm  = {{20{inst_v[31]}}, inst_v[31:20]};
            end
            OPC_LUI, OPC_AUIPC:
            begin
                e.we = 1'b1;
                op   = (inst_v[6:0] == OPC_LUI) ? ALU_LUI : ALU_AUIPC;
                imm  = {inst_v[31:12], 12'b0};
            end
            default:
            begin
            end
        endcase
        a = pick_operand(use1, inst_v[19:15], (op == ALU_AUIPC) ? pc_v : imm, ex, mem);
        b = pick_operand(use2, inst_v[24:20], imm, ex, mem);
        e.valid  = 1'b1;
        e.alu_op = op;
        e.rd     = inst_v[11:7];
        e.op1    = a;
        e.op2    = b;
        e.imm    = imm;
        e.link   = pc_v + 32'd4;
        r.taken  = 1'b0;
        r.target = pc_v + imm;
        case (op)
            ALU_BEQ:  r.taken = a == b;
            ALU_BNE:  r.taken = a != b;
            ALU_BLT:  r.taken = $signed(a) < $signed(b);
            ALU_BGE:  r.taken = $signed(a) >= $signed(b);
            ALU_BLTU: r.taken = a < b;
            ALU_BGEU: r.taken = a >= b;
            ALU_JAL:  r.taken = 1'b1;
            ALU_JALR:
            begin
                r.taken  = 1'b1;
                r.target = (a + imm) & ~32'd1;
            end
            default:  r.taken = 1'b0;
        endcase
        if (!rdy_v)
        begin
            e = last_ex; // Stage holds
            r = last_rd;
        end
        else if (ign_v)
        begin
            e = '0;
            r = '0;
        end
    endfunction

    task automatic check(input string what, input logic [159:0] got, input logic [159:0] exp);
        if (got !== exp)
        begin
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic apply(input word_t inst_v, input word_t pc_v, input fwd_t ex, input fwd_t mem,
                         input wb_t wb_v, input logic rdy_v, input logic ign_v);
        id_ex_t    e;
        redirect_t r;
        inst    = inst_v;
        pc      = pc_v;
        ex_fwd  = ex;
        mem_fwd = mem;
        wb      = wb_v;
        rdy     = rdy_v;
        ignore  = ign_v;
        compute_expected(inst_v, pc_v, ex, mem, rdy_v, ign_v, e, r);
        exp_ex_q.push_back(e);
        exp_rd_q.push_back(r);
        last_ex = e;
        last_rd = r;
        if (wb_v.we && wb_v.addr != '0)
            model_regs[wb_v.addr] = wb_v.data; // Lands at the coming edge
        @(posedge clk);
        #5;
    endtask

    initial
    begin
        forever
        begin
            @(posedge clk);
            if (exp_ex_q.size() != 0)
            begin
                @(negedge clk);
                cmp_ex = exp_ex_q.pop_front();
                cmp_rd = exp_rd_q.pop_front();
                check("id_ex_o", 160'(id_ex), 160'(cmp_ex));
                check("redirect_o", 160'(redirect), 160'(cmp_rd));
                check("next_ignore_o", 160'(next_ignore), 160'(cmp_rd.taken));
            end
        end
    end

    initial
    begin
        #((TOTAL_CYCLES + 50) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

    initial
    begin
        int n;
        rst_n   = 1'b0;
        rdy     = 1'b1;
        ignore  = 1'b0;
        pc      = '0;
        inst    = '0;
        wb      = '0;
        ex_fwd  = '0;
        mem_fwd = '0;
        repeat (4) @(posedge clk);
        #5;
        rst_n = 1'b1;
        @(negedge clk);
        check("valid after reset", 160'(id_ex.valid), '0);
        check("we after reset", 160'(id_ex.we), '0);
        check("taken after reset", 160'(redirect.taken), '0);
        check("next_ignore after reset", 160'(next_ignore), '0);
        @(posedge clk);
        #5;

        for (int i = 1; i < 32; i++)
            apply(rand_alu_inst(), rand_pc(), no_fwd, no_fwd, wb_t'{1'b1, 5'(i), rand_bits(32)},
                  1'b1, 1'b0);
        for (int i = 0; i < N_RAND; i++)
            apply(rand_alu_inst(), rand_pc(), fwd_t'(rand_write()), fwd_t'(rand_write()),
                  wb_t'(rand_write()), 1'b1, 1'b0);

        // Forwarding priority, x0 and same-cycle write
        apply({F7_BASE, 5'd6, 5'd5, F3_ADD, 5'd1, OPC_R}, rand_pc(),
              fwd_t'{1'b1, 5'd5, 32'hAAAA_0001}, fwd_t'{1'b1, 5'd5, 32'hBBBB_0002}, no_wb,
              1'b1, 1'b0);
        apply({F7_BASE, 5'd6, 5'd5, F3_ADD, 5'd1, OPC_R}, rand_pc(),
              fwd_t'{1'b1, 5'd7, 32'hAAAA_0003}, fwd_t'{1'b1, 5'd6, 32'hCCCC_0004}, no_wb,
              1'b1, 1'b0);
        apply({F7_BASE, 5'd0, 5'd0, F3_XOR, 5'd2, OPC_R}, rand_pc(),
              fwd_t'{1'b1, 5'd0, 32'hDEAD_0005}, fwd_t'{1'b1, 5'd0, 32'hBEEF_0006}, no_wb,
              1'b1, 1'b0);
        apply({F7_ALT, 5'd5, 5'd5, F3_ADD, 5'd3, OPC_R}, rand_pc(), no_fwd, no_fwd,
              wb_t'{1'b1, 5'd5, 32'h1234_5678}, 1'b1, 1'b0);
        apply({F7_ALT, 5'd5, 5'd5, F3_ADD, 5'd3, OPC_R}, rand_pc(), no_fwd, no_fwd, no_wb,
              1'b1, 1'b0);

        for (int f = 0; f < 6; f++)
            for (int p = 0; p < 4; p++)
                apply({7'(rand_bits(7)), 5'd4, 5'd3, br_f3[f], 5'(rand_bits(5)), OPC_BRANCH},
                      rand_pc(), fwd_t'{1'b1, 5'd3, pair_a[p]}, fwd_t'{1'b1, 5'd4, pair_b[p]},
                      no_wb, 1'b1, 1'b0);

        for (int i = 0; i < N_JUMP; i++)
        begin
            apply({25'(rand_bits(25)), OPC_JAL}, rand_pc(), no_fwd, no_fwd, no_wb, 1'b1, 1'b0);
            apply({12'(rand_bits(12)), 5'(rand_bits(5)), 3'b000, 5'(rand_bits(5)), OPC_JALR},
                  rand_pc(), no_fwd, no_fwd, no_wb, 1'b1, 1'b0);
        end
        for (int i = 0; i < N_UPPER; i++)
        begin
            apply({25'(rand_bits(25)), OPC_LUI}, rand_pc(), no_fwd, no_fwd, no_wb, 1'b1, 1'b0);
            apply({25'(rand_bits(25)), OPC_AUIPC}, rand_pc(), no_fwd, no_fwd, no_wb, 1'b1, 1'b0);
        end
        apply({25'(rand_bits(25)), 7'b0000011}, rand_pc(), no_fwd, no_fwd, no_wb, 1'b1, 1'b0);

        for (int i = 0; i < N_LEVEL; i++)
        begin
            n = int'(rand_bits(2));
            repeat (n)
                apply(mixed_inst(), rand_pc(), fwd_t'(rand_write()), fwd_t'(rand_write()),
                      wb_t'(rand_write()), 1'b0, 1'(rand_bits(1)));
            apply(mixed_inst(), rand_pc(), fwd_t'(rand_write()), fwd_t'(rand_write()),
                  wb_t'(rand_write()), 1'b1, 1'(rand_bits(1)));
        end

        repeat (2) @(posedge clk);
        if (exp_ex_q.size() == 0)
        begin
            $display("STATUS: PASS");
            $finish;
        end
        else
        begin
            $display("%0d expected results were never compared", exp_ex_q.size());
            $display("STATUS: FAIL");
            $fatal(1, "unchecked results");
        end
    end

endmodule

// File: flist.f
id_pkg.sv
id_imm_gen.sv
id_decoder.sv
id_regfile.sv
id_operand_mux.sv
id_branch_unit.sv
id_stage.sv
id_stage_assert.sv
tb_id_stage.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_id_stage -f flist.f \
    -o sim_id_stage > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_id_stage > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -qx "STATUS: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
